//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_branch_rs
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- branch_rs.sv
`timescale 1ns/1ns
`default_nettype none

module branch_rs #(
   parameter int ENT_NUM    = brs_pkg::DEF_ENT_NUM,
   parameter int NUM_RESULT = brs_pkg::DEF_NUM_RESULT
) (
   input  logic                            clk,
   input  logic                            reset,
   // Allocation
   input  logic                            we1,
   input  logic                            we2,
   input  logic [$clog2(ENT_NUM)-1:0]      waddr1,
   input  logic [$clog2(ENT_NUM)-1:0]      waddr2,
   input  brs_pkg::rs_write_t              wdata1,
   input  brs_pkg::rs_write_t              wdata2,
   input  brs_pkg::result_t                result [NUM_RESULT],
   // Issue
   input  logic                            clearbusy,
   input  logic [$clog2(ENT_NUM)-1:0]      issueaddr,
   // Branch resolution
   input  logic                            prmiss,
   input  logic                            prsuccess,
   input  logic [brs_pkg::SPECTAG_LEN-1:0] prtag,
   input  logic [brs_pkg::SPECTAG_LEN-1:0] specfixtag,
   output logic [ENT_NUM-1:0]              busyvec,
   output logic [ENT_NUM-1:0]              prbusyvec_next,
   output logic [ENT_NUM-1:0]              ready,
   output logic [brs_pkg::DATA_LEN-1:0]    ex_src1,
   output logic [brs_pkg::DATA_LEN-1:0]    ex_src2,
   output brs_pkg::rs_payload_t            payload,
   output logic                            specbit
);

   import brs_pkg::*;

   localparam int ENT_SEL = $clog2(ENT_NUM);

   logic [DATA_LEN-1:0]    ent_src1    [ENT_NUM];
   logic [DATA_LEN-1:0]    ent_src2    [ENT_NUM];
   rs_payload_t            ent_payload [ENT_NUM];
   logic [SPECTAG_LEN-1:0] ent_spectag [ENT_NUM];

   for (genvar e = 0; e < ENT_NUM; e++) begin : g_ent
      logic      sel1;
      logic      sel2;
      rs_write_t wdata;

      // Port 1 wins the entry, else port 2 data is presented
      assign sel1  = we1 && (waddr1 == ENT_SEL'(e));
      assign sel2  = we2 && (waddr2 == ENT_SEL'(e));
      assign wdata = sel1 ? wdata1 : wdata2;

      brs_entry #(.NUM_RESULT(NUM_RESULT)) u_ent (
         .clk     (clk),
         .reset   (reset),
         .busy    (busyvec[e]),
         .we      (sel1 | sel2),
         .wdata   (wdata),
         .result  (result),
         .ex_src1 (ent_src1[e]),
         .ex_src2 (ent_src2[e]),
         .ready   (ready[e]),
         .payload (ent_payload[e])
      );

      assign ent_spectag[e] = ent_payload[e].spectag;
   end

   brs_status #(.ENT_NUM(ENT_NUM)) u_status (
      .clk            (clk),
      .reset          (reset),
      .we1            (we1),
      .we2            (we2),
      .waddr1         (waddr1),
      .waddr2         (waddr2),
      .wspecbit1      (wdata1.specbit),
      .wspecbit2      (wdata2.specbit),
      .clearbusy      (clearbusy),
      .issueaddr      (issueaddr),
      .prmiss         (prmiss),
      .prsuccess      (prsuccess),
      .prtag          (prtag),
      .specfixtag     (specfixtag),
      .ent_spectag    (ent_spectag),
      .busyvec        (busyvec),
      .prbusyvec_next (prbusyvec_next),
      .specbit        (specbit)
   );

   // Same-cycle readout of the issuing entry
   assign ex_src1 = ent_src1[issueaddr];
   assign ex_src2 = ent_src2[issueaddr];
   assign payload = ent_payload[issueaddr];

endmodule

`default_nettype wire

//--- branch_rs_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module branch_rs_asserts #(
   parameter int ENT_NUM = brs_pkg::DEF_ENT_NUM
) (
   input logic                       clk,
   input logic                       reset,
   input logic                       we1,
   input logic                       we2,
   input logic [$clog2(ENT_NUM)-1:0] waddr1,
   input logic [$clog2(ENT_NUM)-1:0] waddr2,
   input logic                       clearbusy,
   input logic [$clog2(ENT_NUM)-1:0] issueaddr,
   input logic                       prmiss,
   input logic                       prsuccess,
   input logic [ENT_NUM-1:0]         busyvec,
   input logic [ENT_NUM-1:0]         prbusyvec_next,
   input logic [ENT_NUM-1:0]         ready
);

   int fail_count = 0;

   task automatic flag_failure(input string msg);
      fail_count++;
      $error("%s", msg);
   endtask

   a_reset: assert property (@(posedge clk) $past(reset) |-> (busyvec == '0 && ready == '0))
      else flag_failure("busy or ready set after reset");
   a_alloc: assert property (@(posedge clk) disable iff (reset)
      ((we1 || we2) && !clearbusy && !prmiss && !prsuccess) |=>
      ((!$past(we1) || busyvec[$past(waddr1)]) && (!$past(we2) || busyvec[$past(waddr2)])))
      else flag_failure("allocated entry not busy after the write edge");
   a_issue: assert property (@(posedge clk) disable iff (reset)
      (clearbusy && !prmiss) |=> (!busyvec[$past(issueaddr)] && !ready[$past(issueaddr)]))
      else flag_failure("issued entry still busy or ready");
   a_miss: assert property (@(posedge clk) disable iff (reset)
      prmiss |=> busyvec == $past(prbusyvec_next))
      else flag_failure("busy set after misprediction differs from survivor set");

   // Upstream allocation rules
   a_free_only: assert property (@(posedge clk) disable iff (reset)
      !(we1 && busyvec[waddr1]) && !(we2 && busyvec[waddr2]))
      else flag_failure("allocation to a busy entry");
   a_distinct: assert property (@(posedge clk) disable iff (reset)
      !(we1 && we2 && waddr1 == waddr2))
      else flag_failure("both ports allocate the same entry");
   a_no_resolve: assert property (@(posedge clk) disable iff (reset)
      !((we1 || we2) && (prmiss || prsuccess)))
      else flag_failure("allocation during branch resolution");

endmodule

bind branch_rs branch_rs_asserts #(.ENT_NUM(ENT_NUM)) u_asserts (
   .clk            (clk),
   .reset          (reset),
   .we1            (we1),
   .we2            (we2),
   .waddr1         (waddr1),
   .waddr2         (waddr2),
   .clearbusy      (clearbusy),
   .issueaddr      (issueaddr),
   .prmiss         (prmiss),
   .prsuccess      (prsuccess),
   .busyvec        (busyvec),
   .prbusyvec_next (prbusyvec_next),
   .ready          (ready)
);

`default_nettype wire

//--- brs_entry.sv
`timescale 1ns/1ns
`default_nettype none

module brs_entry #(
   parameter int NUM_RESULT = brs_pkg::DEF_NUM_RESULT
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         busy,
   input  logic                         we,
   input  brs_pkg::rs_write_t           wdata,
   input  brs_pkg::result_t             result [NUM_RESULT],
   output logic [brs_pkg::DATA_LEN-1:0] ex_src1,
   output logic [brs_pkg::DATA_LEN-1:0] ex_src2,
   output logic                         ready,
   output brs_pkg::rs_payload_t         payload
);

   import brs_pkg::*;

   logic [DATA_LEN-1:0] src1;
   logic [DATA_LEN-1:0] src2;
   logic                valid1;
   logic                valid2;

   logic [DATA_LEN-1:0] src1_next;
   logic [DATA_LEN-1:0] src2_next;
   logic                valid1_next;
   logic                valid2_next;

   operand_wakeup #(.NUM_RESULT(NUM_RESULT)) u_wake1 (
      .opr      (src1),
      .opr_rdy  (valid1),
      .result   (result),
      .src      (src1_next),
      .resolved (valid1_next)
   );

   operand_wakeup #(.NUM_RESULT(NUM_RESULT)) u_wake2 (
      .opr      (src2),
      .opr_rdy  (valid2),
      .result   (result),
      .src      (src2_next),
      .resolved (valid2_next)
   );

   // Wakeup output equals the held value unless a bus hit this cycle
   assign ex_src1 = src1_next;
   assign ex_src2 = src2_next;
   assign ready   = busy & valid1 & valid2;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
      end else if (we) begin
         valid1 <= wdata.valid1;
         valid2 <= wdata.valid2;
      end else begin
         valid1 <= valid1_next;
         valid2 <= valid2_next;
      end
   end

   always_ff @(posedge clk) begin
      if (we) begin
         payload <= wdata.payload;
         src1    <= wdata.src1;
         src2    <= wdata.src2;
      end else begin
         src1 <= src1_next;  // Captures the woken value
         src2 <= src2_next;
      end
   end

endmodule

`default_nettype wire

//--- brs_pkg.sv
`default_nettype none

package brs_pkg;

   parameter int DATA_LEN     = 32;
   parameter int ADDR_LEN     = 32;
   parameter int RRF_SEL      = 6;
   parameter int SPECTAG_LEN  = 5;  // One-hot
   parameter int ALU_OP_WIDTH = 4;
   parameter int OPCODE_LEN   = 7;

   parameter int DEF_ENT_NUM    = 4;
   parameter int DEF_NUM_RESULT = 3;

   // Static part of a branch entry, read out at issue
   typedef struct packed {
      logic [ADDR_LEN-1:0]     pc;
      logic [DATA_LEN-1:0]     imm;
      logic [RRF_SEL-1:0]      rrftag;
      logic                    dstval;
      logic [ALU_OP_WIDTH-1:0] alu_op;
      logic [SPECTAG_LEN-1:0]  spectag;
      logic [OPCODE_LEN-1:0]   opcode;
   } rs_payload_t;

   // Allocation word from dispatch
   typedef struct packed {
      rs_payload_t         payload;
      logic [DATA_LEN-1:0] src1;     // Rename tag in low bits if not valid
      logic [DATA_LEN-1:0] src2;
      logic                valid1;
      logic                valid2;
      logic                specbit;
   } rs_write_t;

   // One result bus from an execution unit
   typedef struct packed {
      logic [DATA_LEN-1:0] data;
      logic [RRF_SEL-1:0]  dst;
      logic                kill_spec;
   } result_t;

endpackage

`default_nettype wire

//--- brs_status.sv
`timescale 1ns/1ns
`default_nettype none

module brs_status #(
   parameter int ENT_NUM = brs_pkg::DEF_ENT_NUM
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            we1,
   input  logic                            we2,
   input  logic [$clog2(ENT_NUM)-1:0]      waddr1,
   input  logic [$clog2(ENT_NUM)-1:0]      waddr2,
   input  logic                            wspecbit1,
   input  logic                            wspecbit2,
   input  logic                            clearbusy,
   input  logic [$clog2(ENT_NUM)-1:0]      issueaddr,
   input  logic                            prmiss,
   input  logic                            prsuccess,
   input  logic [brs_pkg::SPECTAG_LEN-1:0] prtag,
   input  logic [brs_pkg::SPECTAG_LEN-1:0] specfixtag,
   input  logic [brs_pkg::SPECTAG_LEN-1:0] ent_spectag [ENT_NUM],
   output logic [ENT_NUM-1:0]              busyvec,
   output logic [ENT_NUM-1:0]              prbusyvec_next,
   output logic                            specbit
);

   logic [ENT_NUM-1:0] specbitvec;
   logic [ENT_NUM-1:0] specbitvec_next;
   logic [ENT_NUM-1:0] survive;    // Entry not on the mispredicted path
   logic [ENT_NUM-1:0] keep_spec;

   always_comb begin
      for (int i = 0; i < ENT_NUM; i++) begin
         survive[i]   = (ent_spectag[i] & specfixtag) == '0;
         keep_spec[i] = ent_spectag[i] != prtag;
      end
   end

   assign prbusyvec_next  = busyvec & survive;
   assign specbitvec_next = specbitvec & keep_spec;

   // Show the resolved bit in the success cycle itself
   assign specbit = prsuccess ? specbitvec_next[issueaddr] : specbitvec[issueaddr];

   // Upstream holds off allocation while prmiss or prsuccess is high
   always_ff @(posedge clk) begin
      if (reset) begin
         busyvec    <= '0;
         specbitvec <= '0;
      end else if (prmiss) begin
         busyvec    <= prbusyvec_next;
         specbitvec <= '0;
      end else if (prsuccess) begin
         specbitvec <= specbitvec_next;
         if (clearbusy) begin
            busyvec[issueaddr] <= 1'b0;
         end
      end else begin
         if (we1) begin
            busyvec[waddr1]    <= 1'b1;
            specbitvec[waddr1] <= wspecbit1;
         end
         if (we2) begin
            busyvec[waddr2]    <= 1'b1;
            specbitvec[waddr2] <= wspecbit2;
         end
         if (clearbusy) begin
            busyvec[issueaddr] <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- operand_wakeup.sv
`timescale 1ns/1ns
`default_nettype none

module operand_wakeup #(
   parameter int NUM_RESULT = brs_pkg::DEF_NUM_RESULT
) (
   input  logic [brs_pkg::DATA_LEN-1:0] opr,
   input  logic                         opr_rdy,
   input  brs_pkg::result_t             result [NUM_RESULT],
   output logic [brs_pkg::DATA_LEN-1:0] src,
   output logic                         resolved
);

   import brs_pkg::*;

   logic [RRF_SEL-1:0] tag;

   assign tag = opr[RRF_SEL-1:0];

   // Buses carry distinct tags, so at most one hit per cycle
   always_comb begin
      src      = opr;
      resolved = opr_rdy;
      if (!opr_rdy) begin
         for (int i = 0; i < NUM_RESULT; i++) begin
            if (!result[i].kill_spec && (result[i].dst == tag)) begin
               src      = result[i].data;
               resolved = 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- sim.f
brs_pkg.sv
operand_wakeup.sv
brs_entry.sv
brs_status.sv
branch_rs.sv
branch_rs_asserts.sv
tb_branch_rs.sv

//--- tb_branch_rs.sv
`timescale 1ns/1ns
`default_nettype none

module tb_branch_rs;

   import brs_pkg::*;

   localparam int ENT_NUM    = DEF_ENT_NUM;
   localparam int NUM_RESULT = DEF_NUM_RESULT;
   localparam int ENT_SEL    = $clog2(ENT_NUM);
   localparam int W          = 128;   // Wide enough for the payload
   localparam int MAX_CYCLES = 2000;

   logic                   clk;
   logic                   reset;
   logic                   we1, we2;
   logic [ENT_SEL-1:0]     waddr1, waddr2, issueaddr;
   rs_write_t              wdata1, wdata2;
   result_t                result [NUM_RESULT];
   logic                   clearbusy, prmiss, prsuccess;
   logic [SPECTAG_LEN-1:0] prtag, specfixtag;
   logic [ENT_NUM-1:0]     busyvec, prbusyvec_next, ready;
   logic [DATA_LEN-1:0]    ex_src1, ex_src2;
   rs_payload_t            payload;
   logic                   specbit;

   rs_write_t          m_ent [ENT_NUM];   // Shadow model
   logic [ENT_NUM-1:0] m_busy;
   logic [ENT_NUM-1:0] m_spec;
   int                 value_errors = 0;
   int                 cycles = 0;

   branch_rs #(.ENT_NUM(ENT_NUM), .NUM_RESULT(NUM_RESULT)) UUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the test did not finish", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   function automatic rs_write_t rand_write(input logic [RRF_SEL-1:0] t1,
                                            input logic [RRF_SEL-1:0] t2,
                                            input logic v1, input logic v2);
      rs_write_t w;
      w.payload.pc      = $urandom;
      w.payload.imm     = $urandom;
      w.payload.rrftag  = RRF_SEL'($urandom);
      w.payload.dstval  = 1'($urandom);
      w.payload.alu_op  = ALU_OP_WIDTH'($urandom);
      w.payload.spectag = SPECTAG_LEN'(1 << ($urandom % SPECTAG_LEN));
      w.payload.opcode  = OPCODE_LEN'($urandom);
      w.src1    = $urandom;
      w.src2    = $urandom;
      if (!v1) w.src1[RRF_SEL-1:0] = t1;   // Waiting operand keeps its tag
      if (!v2) w.src2[RRF_SEL-1:0] = t2;
      w.valid1  = v1;
      w.valid2  = v2;
      w.specbit = 1'($urandom);
      return w;
   endfunction

   function automatic result_t make_result(input logic [DATA_LEN-1:0] d,
                                           input logic [RRF_SEL-1:0] t, input logic k);
      result_t r;
      r.data      = d;
      r.dst       = t;
      r.kill_spec = k;
      return r;
   endfunction

   function automatic logic [ENT_NUM-1:0] exp_ready();
      logic [ENT_NUM-1:0] r;
      for (int e = 0; e < ENT_NUM; e++) begin
         r[e] = m_busy[e] & m_ent[e].valid1 & m_ent[e].valid2;
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
      assert (exp == act) else begin
         value_errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic set_idle();
      for (int i = 0; i < NUM_RESULT; i++) begin
         result[i] <= make_result('0, '0, 1'b1);   // Killed bus never matches
      end
   endtask

   task automatic alloc(input logic en1, input logic [ENT_SEL-1:0] a1, input rs_write_t w1,
                        input logic en2, input logic [ENT_SEL-1:0] a2, input rs_write_t w2);
      @(posedge clk);
      we1    <= en1;
      waddr1 <= a1;
      wdata1 <= w1;
      we2    <= en2;
      waddr2 <= a2;
      wdata2 <= w2;
      @(posedge clk);
      we1 <= 1'b0;
      we2 <= 1'b0;
      if (en1) begin
         m_ent[a1]  = w1;
         m_busy[a1] = 1'b1;
         m_spec[a1] = w1.specbit;
      end
      if (en2) begin
         m_ent[a2]  = w2;
         m_busy[a2] = 1'b1;
         m_spec[a2] = w2.specbit;
      end
   endtask

   task automatic refill();
      rs_write_t w;
      for (int e = 0; e < ENT_NUM; e++) begin
         if (!m_busy[e]) begin
            w = rand_write(RRF_SEL'($urandom), RRF_SEL'($urandom), 1'($urandom), 1'($urandom));
            alloc(1'b1, ENT_SEL'(e), w, 1'b0, '0, '0);
         end
      end
   endtask

   task automatic check_entry(input logic [ENT_SEL-1:0] a);
      @(posedge clk);
      issueaddr <= a;
      @(negedge clk);
      check("busyvec", W'(m_busy), W'(busyvec));
      check("ready", W'(exp_ready()), W'(ready));
      check("specbit", W'(m_spec[a]), W'(specbit));
      if (m_busy[a]) begin
         check("payload", W'(m_ent[a].payload), W'(payload));
         check("ex_src1", W'(m_ent[a].src1), W'(ex_src1));
         check("ex_src2", W'(m_ent[a].src2), W'(ex_src2));
      end
   endtask

   task automatic check_all();
      for (int a = 0; a < ENT_NUM; a++) begin
         check_entry(ENT_SEL'(a));
      end
   endtask

   initial begin
      logic [RRF_SEL-1:0]     t2, t3;
      logic [DATA_LEN-1:0]    d2, d3;
      logic [SPECTAG_LEN-1:0] tag;
      logic [ENT_NUM-1:0]     surv;
      rs_write_t              w0;
      void'($urandom(32'he620));
      reset      = 1'b1;
      we1        = 1'b0;
      we2        = 1'b0;
      waddr1     = '0;
      waddr2     = '0;
      wdata1     = '0;
      wdata2     = '0;
      clearbusy  = 1'b0;
      issueaddr  = '0;
      prmiss     = 1'b0;
      prsuccess  = 1'b0;
      prtag      = '0;
      specfixtag = '0;
      m_busy     = '0;
      m_spec     = '0;
      set_idle();
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      check_all();

      // Two ready entries, then two waiting on distinct tags
      t2 = RRF_SEL'($urandom);
      t3 = t2 + RRF_SEL'(1 + $urandom % 63);
      d2 = $urandom;
      d3 = $urandom;
      w0 = rand_write('0, '0, 1'b1, 1'b1);
      w0.specbit = 1'b1;   // Resolved later by prsuccess
      alloc(1'b1, ENT_SEL'(0), w0,
            1'b1, ENT_SEL'(1), rand_write('0, '0, 1'b1, 1'b1));
      alloc(1'b1, ENT_SEL'(2), rand_write(t2, '0, 1'b0, 1'b1),
            1'b1, ENT_SEL'(3), rand_write('0, t3, 1'b1, 1'b0));
      check_all();

      @(posedge clk);
      issueaddr <= ENT_SEL'(2);
      result[1] <= make_result(d2, t2, 1'b1);
      @(negedge clk);
      check("ex_src1", W'(m_ent[2].src1), W'(ex_src1));
      @(posedge clk);
      set_idle();
      @(negedge clk);
      check("ex_src1", W'(m_ent[2].src1), W'(ex_src1));
      check("ready", W'(exp_ready()), W'(ready));

      @(posedge clk);
      result[0] <= make_result(d2, t2, 1'b0);
      result[2] <= make_result(d3, t3, 1'b0);
      @(negedge clk);
      check("ex_src1", W'(d2), W'(ex_src1));   // Forwarded
      check("ready", W'(exp_ready()), W'(ready));
      @(posedge clk);
      set_idle();
      m_ent[2].src1   = d2;
      m_ent[2].valid1 = 1'b1;
      m_ent[3].src2   = d3;
      m_ent[3].valid2 = 1'b1;
      @(negedge clk);
      check("ready", W'(exp_ready()), W'(ready));
      check_all();

      @(posedge clk);
      issueaddr <= ENT_SEL'(1);
      clearbusy <= 1'b1;
      @(posedge clk);
      clearbusy <= 1'b0;
      m_busy[1] = 1'b0;
      check_all();

      refill();
      tag = m_ent[0].payload.spectag;
      @(posedge clk);
      prsuccess <= 1'b1;
      prtag     <= tag;
      issueaddr <= '0;
      for (int e = 0; e < ENT_NUM; e++) begin
         if (m_ent[e].payload.spectag == tag) m_spec[e] = 1'b0;
      end
      @(negedge clk);
      check("specbit", W'(m_spec[0]), W'(specbit));
      @(posedge clk);
      prsuccess <= 1'b0;
      check_all();

      repeat (4) begin
         refill();
         tag = SPECTAG_LEN'($urandom);
         @(posedge clk);
         prmiss     <= 1'b1;
         specfixtag <= tag;
         for (int e = 0; e < ENT_NUM; e++) begin
            surv[e] = m_busy[e] && ((m_ent[e].payload.spectag & tag) == '0);
         end
         @(negedge clk);
         check("prbusyvec_next", W'(surv), W'(prbusyvec_next));
         @(posedge clk);
         prmiss <= 1'b0;
         m_busy = surv;
         m_spec = '0;
         check_all();
      end

      $display("Closing: %0d value errors, %0d assertion errors",
               value_errors, UUT.u_asserts.fail_count);
      if (value_errors == 0 && UUT.u_asserts.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
